//--- tb.f
src/uc_pkg.sv
src/cmd_router.sv
src/resp_router.sv
src/clint_slice.sv
src/loopback_slice.sv
src/uncore_lite.sv
verification/uncore_tb.sv

//--- verification/uncore_tb.sv
`timescale 1ns/1ps

// External memory or I/O model, one command at a time with a random delay
module ext_responder
  import uc_pkg::*;
#(
  parameter logic [DATA_W-1:0] READ_KEY = '0
)
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              hold_i,
  input  logic              cmd_v_i,
  input  mem_op_e           cmd_opcode_i,
  input  addr_u             cmd_addr_i,
  input  lce_id_t           cmd_lce_id_i,
  output logic              cmd_ready_o,
  output logic              resp_v_o,
  output mem_op_e           resp_opcode_o,
  output addr_u             resp_addr_o,
  output lce_id_t           resp_lce_id_o,
  output logic [DATA_W-1:0] resp_data_o,
  input  logic              resp_taken_i
);

  integer  seed;
  logic    busy;
  logic    accept_q;
  logic    done_q;
  int      wait_cnt;
  mem_op_e op_q;
  addr_u   addr_q;
  lce_id_t lce_q;

  initial
  begin
    seed          = 57;
    busy          = 1'b0;
    accept_q      = 1'b0;
    done_q        = 1'b0;
    wait_cnt      = 0;
    resp_v_o      = 1'b0;
    resp_opcode_o = op_read;
    resp_addr_o   = '0;
    resp_lce_id_o = '0;
    resp_data_o   = '0;
  end

  assign cmd_ready_o = ~busy & ~hold_i;

  always @(negedge clk_i)
  begin
    if (rst_i)
    begin
      busy     = 1'b0;
      resp_v_o = 1'b0;
    end
    else
    begin
      if (done_q)
      begin
        resp_v_o = 1'b0;
        busy     = 1'b0;
      end
      if (accept_q)
      begin
        busy          = 1'b1;
        wait_cnt      = $unsigned($random(seed)) % 4;
        resp_opcode_o = op_q;
        resp_addr_o   = addr_q;
        resp_lce_id_o = lce_q;
        if (op_q == op_write)
          resp_data_o = '0;
        else
          resp_data_o = {{(DATA_W-PADDR_W){1'b0}}, addr_q.paddr} ^ READ_KEY;
      end
      if (busy && !resp_v_o)
      begin
        if (wait_cnt == 0)
          resp_v_o = 1'b1;
        else
          wait_cnt = wait_cnt - 1;
      end
    end
    // Handshakes seen here fire on the coming rising edge
    #1;
    accept_q = cmd_v_i;
    done_q   = resp_v_o & resp_taken_i;
    if (cmd_v_i)
    begin
      op_q   = cmd_opcode_i;
      addr_q = cmd_addr_i;
      lce_q  = cmd_lce_id_i;
    end
  end

endmodule

module uncore_tb
  import uc_pkg::*;
();

  localparam logic [DATA_W-1:0] READ_KEY = 64'h5A5A_0F0F_C3C3_1234;
  localparam int NUM_ENTRIES    = 18;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 20 + 200;
  localparam int TGT_MEM   = 0;
  localparam int TGT_IO    = 1;
  localparam int TGT_CLINT = 2;
  localparam int TGT_LOOP  = 3;
  // Entries followed by an interrupt check
  localparam int MSIP_SET_IDX   = 8;
  localparam int CMP_SMALL_IDX  = 11;
  localparam int CMP_ONES_IDX   = 16;

  logic              clk_i;
  logic              rst_i;
  logic              mem_hold;
  logic              req_cmd_v_i      [NUM_REQ];
  mem_op_e           req_cmd_opcode_i [NUM_REQ];
  addr_u             req_cmd_addr_i   [NUM_REQ];
  logic [DATA_W-1:0] req_cmd_data_i   [NUM_REQ];
  logic              req_cmd_yumi_o   [NUM_REQ];
  logic              req_resp_v_o     [NUM_REQ];
  logic              req_resp_ready_i [NUM_REQ];
  mem_op_e           req_resp_opcode_o;
  addr_u             req_resp_addr_o;
  logic [DATA_W-1:0] req_resp_data_o;
  logic              mem_cmd_v_o, mem_cmd_ready_i, io_cmd_v_o, io_cmd_ready_i;
  mem_op_e           mem_cmd_opcode_o, io_cmd_opcode_o, mem_resp_opcode_i, io_resp_opcode_i;
  addr_u             mem_cmd_addr_o, io_cmd_addr_o, mem_resp_addr_i, io_resp_addr_i;
  lce_id_t           mem_cmd_lce_id_o, io_cmd_lce_id_o, mem_resp_lce_id_i, io_resp_lce_id_i;
  logic [DATA_W-1:0] mem_cmd_data_o, io_cmd_data_o, mem_resp_data_i, io_resp_data_i;
  logic              mem_resp_v_i, mem_resp_ready_o, io_resp_v_i, io_resp_yumi_o;
  logic              timer_irq_o, software_irq_o;

  int                cycle_cnt = 0;
  int                n_entries = 0;
  int                tbl_req    [NUM_ENTRIES];
  mem_op_e           tbl_op     [NUM_ENTRIES];
  addr_u             tbl_addr   [NUM_ENTRIES];
  logic [DATA_W-1:0] tbl_wdata  [NUM_ENTRIES];
  int                tbl_tgt    [NUM_ENTRIES];
  int                tbl_cstall [NUM_ENTRIES];
  int                tbl_rstall [NUM_ENTRIES];
  logic [DATA_W-1:0] tbl_exp    [NUM_ENTRIES];

  uncore_lite uut (.*);

  ext_responder #(.READ_KEY(READ_KEY)) mem_model (
    .clk_i(clk_i), .rst_i(rst_i), .hold_i(mem_hold),
    .cmd_v_i(mem_cmd_v_o), .cmd_opcode_i(mem_cmd_opcode_o), .cmd_addr_i(mem_cmd_addr_o),
    .cmd_lce_id_i(mem_cmd_lce_id_o), .cmd_ready_o(mem_cmd_ready_i),
    .resp_v_o(mem_resp_v_i), .resp_opcode_o(mem_resp_opcode_i), .resp_addr_o(mem_resp_addr_i),
    .resp_lce_id_o(mem_resp_lce_id_i), .resp_data_o(mem_resp_data_i),
    .resp_taken_i(mem_resp_ready_o)
  );

  ext_responder #(.READ_KEY(READ_KEY)) io_model (
    .clk_i(clk_i), .rst_i(rst_i), .hold_i(1'b0),
    .cmd_v_i(io_cmd_v_o), .cmd_opcode_i(io_cmd_opcode_o), .cmd_addr_i(io_cmd_addr_o),
    .cmd_lce_id_i(io_cmd_lce_id_o), .cmd_ready_o(io_cmd_ready_i),
    .resp_v_o(io_resp_v_i), .resp_opcode_o(io_resp_opcode_i), .resp_addr_o(io_resp_addr_i),
    .resp_lce_id_o(io_resp_lce_id_i), .resp_data_o(io_resp_data_i),
    .resp_taken_i(io_resp_yumi_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      fail_run($sformatf("Simulation timed out after %0d cycles", cycle_cnt));
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_addr(input addr_u got, input addr_u exp, input string what);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_lce(input lce_id_t got, input lce_id_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_op(input mem_op_e got, input mem_op_e exp, input string what);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  // Memory and I/O read data is the address mixed with a fixed key
  function automatic logic [DATA_W-1:0] read_word(input logic [PADDR_W-1:0] a);
    return {{(DATA_W-PADDR_W){1'b0}}, a} ^ READ_KEY;
  endfunction

  task automatic add_entry(input int r, input mem_op_e op, input logic [PADDR_W-1:0] a,
                           input logic [DATA_W-1:0] wd, input int tgt, input int cs,
                           input int rs, input logic [DATA_W-1:0] exp);
    tbl_req[n_entries]       = r;
    tbl_op[n_entries]        = op;
    tbl_addr[n_entries].paddr = a;
    tbl_wdata[n_entries]     = wd;
    tbl_tgt[n_entries]       = tgt;
    tbl_cstall[n_entries]    = cs;
    tbl_rstall[n_entries]    = rs;
    tbl_exp[n_entries]       = exp;
    n_entries++;
  endtask

  task automatic build_table();
    add_entry(0, op_read,  32'h8000_1000, '0, TGT_MEM, 0, 0, read_word(32'h8000_1000));
    add_entry(1, op_write, 32'h8000_2000, 64'h1111_2222, TGT_MEM, 0, 0, '0);
    add_entry(2, op_read,  32'h0030_0040, '0, TGT_MEM, 0, 0, read_word(32'h0030_0040));
    add_entry(1, op_read,  32'h0000_0100, '0, TGT_IO, 0, 0, read_word(32'h0000_0100));
    add_entry(2, op_write, 32'h1000_0000, 64'hABCD, TGT_IO, 0, 0, '0);
    add_entry(0, op_read,  32'h0020_0010, '0, TGT_LOOP, 0, 0, '0);
    add_entry(1, op_write, 32'h0150_0000, 64'h77, TGT_LOOP, 0, 0, '0);
    add_entry(2, op_read,  32'h7FF0_0008, '0, TGT_LOOP, 0, 0, '0);
    add_entry(1, op_write, 32'h0010_0000, 64'h1, TGT_CLINT, 0, 0, '0);
    add_entry(0, op_read,  32'h0010_0000, '0, TGT_CLINT, 0, 0, 64'h1);
    add_entry(2, op_read,  32'h0010_1234, '0, TGT_CLINT, 0, 0, '0);
    add_entry(1, op_write, 32'h0010_4000, 64'h40, TGT_CLINT, 0, 0, '0);
    add_entry(1, op_read,  32'h0010_4000, '0, TGT_CLINT, 0, 0, 64'h40);
    add_entry(0, op_read,  32'h8000_3000, '0, TGT_MEM, 5, 0, read_word(32'h8000_3000));
    add_entry(1, op_read,  32'h0000_0200, '0, TGT_IO, 0, 4, read_word(32'h0000_0200));
    add_entry(2, op_read,  32'h0020_0000, '0, TGT_LOOP, 0, 3, '0);
    add_entry(1, op_write, 32'h0010_4000, '1, TGT_CLINT, 0, 0, '0);
    add_entry(0, op_read,  32'h0010_4000, '0, TGT_CLINT, 0, 0, '1);
  endtask

  task automatic run_entry(input int e);
    int   r;
    int   mem_seen;
    int   io_seen;
    int   hold_left;
    int   stall_left;
    logic got_yumi;
    logic done;
    r          = tbl_req[e];
    mem_seen   = 0;
    io_seen    = 0;
    hold_left  = tbl_cstall[e];
    stall_left = tbl_rstall[e];
    got_yumi   = 1'b0;
    done       = 1'b0;
    @(negedge clk_i);
    req_cmd_v_i[r]      = 1'b1;
    req_cmd_opcode_i[r] = tbl_op[e];
    req_cmd_addr_i[r]   = tbl_addr[e];
    req_cmd_data_i[r]   = tbl_wdata[e];
    mem_hold            = (hold_left > 0);
    req_resp_ready_i[r] = (stall_left == 0);
    while (!done)
    begin
      #1;
      mem_seen += mem_cmd_v_o;
      io_seen  += io_cmd_v_o;
      if (hold_left > 0)
      begin
        if (req_cmd_yumi_o[r])
          fail_run($sformatf("Requester %0d got yumi while memory was not ready", r));
        check_addr(mem_cmd_addr_o, tbl_addr[e], "mem_cmd_addr_o under back-pressure");
        hold_left--;
      end
      if (req_cmd_yumi_o[r] && !got_yumi)
      begin
        got_yumi = 1'b1;
        if (tbl_tgt[e] == TGT_MEM)
        begin
          check_op(mem_cmd_opcode_o, tbl_op[e], "mem_cmd_opcode_o");
          check_addr(mem_cmd_addr_o, tbl_addr[e], "mem_cmd_addr_o");
          check_lce(mem_cmd_lce_id_o, lce_id_t'(r), "mem_cmd_lce_id_o");
          check_data(mem_cmd_data_o, tbl_wdata[e], "mem_cmd_data_o");
        end
        if (tbl_tgt[e] == TGT_IO)
        begin
          check_op(io_cmd_opcode_o, tbl_op[e], "io_cmd_opcode_o");
          check_addr(io_cmd_addr_o, tbl_addr[e], "io_cmd_addr_o");
          check_lce(io_cmd_lce_id_o, lce_id_t'(r), "io_cmd_lce_id_o");
          check_data(io_cmd_data_o, tbl_wdata[e], "io_cmd_data_o");
        end
      end
      for (int i = 0; i < NUM_REQ; i++)
      begin
        if (req_resp_v_o[i] && i != r)
          fail_run($sformatf("Response for requester %0d arrived on requester %0d", r, i));
      end
      if (req_resp_v_o[r])
      begin
        if (!got_yumi)
          fail_run("A response arrived before its command was accepted");
        check_data(req_resp_data_o, tbl_exp[e], $sformatf("response data of entry %0d", e));
        check_addr(req_resp_addr_o, tbl_addr[e], $sformatf("response addr of entry %0d", e));
        check_op(req_resp_opcode_o, tbl_op[e], $sformatf("response opcode of entry %0d", e));
        if (req_resp_ready_i[r])
          done = 1'b1;
        else
          stall_left--;
      end
      @(negedge clk_i);
      if (got_yumi)
        req_cmd_v_i[r] = 1'b0;
      mem_hold            = (hold_left > 0);
      req_resp_ready_i[r] = (stall_left == 0);
    end
    check_count(mem_seen, (tbl_tgt[e] == TGT_MEM) ? 1 : 0, "commands on mem_cmd");
    check_count(io_seen, (tbl_tgt[e] == TGT_IO) ? 1 : 0, "commands on io_cmd");
    req_resp_ready_i[r] = 1'b1;
  endtask

  task automatic wait_timer_irq();
    int n;
    n = 0;
    while (!timer_irq_o && n < 50)
    begin
      @(negedge clk_i);
      n++;
    end
    check_irq(timer_irq_o, 1'b1, "timer_irq_o after small mtimecmp");
  endtask

  task automatic after_entry(input int e);
    if (e == MSIP_SET_IDX)
      check_irq(software_irq_o, 1'b1, "software_irq_o after msip write");
    else if (e == CMP_SMALL_IDX)
      wait_timer_irq();
    else if (e == CMP_ONES_IDX)
      check_irq(timer_irq_o, 1'b0, "timer_irq_o after mtimecmp all ones");
  endtask

  // All three requesters hit memory together
  task automatic check_priority();
    addr_u   a     [NUM_REQ];
    logic    taken [NUM_REQ];
    lce_id_t order [$];
    int      n_resp;
    n_resp = 0;
    @(negedge clk_i);
    for (int i = 0; i < NUM_REQ; i++)
    begin
      a[i].paddr          = 32'h8000_4000 + 32'h100 * i;
      taken[i]            = 1'b0;
      req_cmd_v_i[i]      = 1'b1;
      req_cmd_opcode_i[i] = op_read;
      req_cmd_addr_i[i]   = a[i];
      req_cmd_data_i[i]   = '0;
    end
    while (n_resp < NUM_REQ)
    begin
      #1;
      if (mem_cmd_v_o)
        order.push_back(mem_cmd_lce_id_o);
      for (int i = 0; i < NUM_REQ; i++)
      begin
        if (req_cmd_yumi_o[i])
          taken[i] = 1'b1;
        if (req_resp_v_o[i])
        begin
          check_data(req_resp_data_o, read_word(a[i].paddr), "priority response data");
          check_op(req_resp_opcode_o, op_read, "priority response opcode");
          n_resp++;
        end
      end
      @(negedge clk_i);
      for (int i = 0; i < NUM_REQ; i++)
      begin
        if (taken[i])
          req_cmd_v_i[i] = 1'b0;
      end
    end
    check_count(order.size(), NUM_REQ, "memory commands in priority test");
    for (int i = 0; i < NUM_REQ; i++)
      check_lce(order[i], lce_id_t'(NUM_REQ - 1 - i), $sformatf("memory grant %0d", i));
  endtask

  initial
  begin
    clk_i    = 1'b0;
    rst_i    = 1'b1;
    mem_hold = 1'b0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      req_cmd_v_i[i]      = 1'b0;
      req_cmd_opcode_i[i] = op_read;
      req_cmd_addr_i[i]   = '0;
      req_cmd_data_i[i]   = '0;
      req_resp_ready_i[i] = 1'b1;
    end
    build_table();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    check_irq(timer_irq_o, 1'b0, "timer_irq_o after reset");
    check_irq(software_irq_o, 1'b0, "software_irq_o after reset");
    for (int e = 0; e < n_entries; e++)
    begin
      run_entry(e);
      after_entry(e);
    end
    check_priority();
    $display("Test passed");
    $finish;
  end

endmodule

//--- src/uncore_lite.sv
`timescale 1ns/1ps

module uncore_lite
  import uc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  // Requesters: 0 instruction, 1 data, 2 incoming I/O
  input  logic              req_cmd_v_i      [NUM_REQ],
  input  mem_op_e           req_cmd_opcode_i [NUM_REQ],
  input  addr_u             req_cmd_addr_i   [NUM_REQ],
  input  logic [DATA_W-1:0] req_cmd_data_i   [NUM_REQ],
  output logic              req_cmd_yumi_o   [NUM_REQ],
  output logic              req_resp_v_o     [NUM_REQ],
  input  logic              req_resp_ready_i [NUM_REQ],
  output mem_op_e           req_resp_opcode_o,
  output addr_u             req_resp_addr_o,
  output logic [DATA_W-1:0] req_resp_data_o,

  output logic              mem_cmd_v_o,
  input  logic              mem_cmd_ready_i,
  output mem_op_e           mem_cmd_opcode_o,
  output addr_u             mem_cmd_addr_o,
  output lce_id_t           mem_cmd_lce_id_o,
  output logic [DATA_W-1:0] mem_cmd_data_o,

  output logic              io_cmd_v_o,
  input  logic              io_cmd_ready_i,
  output mem_op_e           io_cmd_opcode_o,
  output addr_u             io_cmd_addr_o,
  output lce_id_t           io_cmd_lce_id_o,
  output logic [DATA_W-1:0] io_cmd_data_o,

  input  logic              mem_resp_v_i,
  input  mem_op_e           mem_resp_opcode_i,
  input  addr_u             mem_resp_addr_i,
  input  lce_id_t           mem_resp_lce_id_i,
  input  logic [DATA_W-1:0] mem_resp_data_i,
  output logic              mem_resp_ready_o,

  input  logic              io_resp_v_i,
  input  mem_op_e           io_resp_opcode_i,
  input  addr_u             io_resp_addr_i,
  input  lce_id_t           io_resp_lce_id_i,
  input  logic [DATA_W-1:0] io_resp_data_i,
  output logic              io_resp_yumi_o,

  output logic              timer_irq_o,
  output logic              software_irq_o
);

  mem_op_e           cmd_opcode;
  addr_u             cmd_addr;
  lce_id_t           cmd_lce_id;
  logic [DATA_W-1:0] cmd_data;

  logic              clint_cmd_v, clint_cmd_ready;
  logic              loop_cmd_v, loop_cmd_ready;

  logic              clint_resp_v, loop_resp_v;
  mem_op_e           clint_resp_opcode, loop_resp_opcode;
  addr_u             clint_resp_addr, loop_resp_addr;
  lce_id_t           clint_resp_lce_id, loop_resp_lce_id;
  logic [DATA_W-1:0] clint_resp_data, loop_resp_data;

  logic              src_v      [NUM_SRC];
  mem_op_e           src_opcode [NUM_SRC];
  addr_u             src_addr   [NUM_SRC];
  lce_id_t           src_lce_id [NUM_SRC];
  logic [DATA_W-1:0] src_data   [NUM_SRC];
  logic              src_yumi   [NUM_SRC];

  cmd_router u_cmd_router (
    .req_cmd_v_i      (req_cmd_v_i),
    .req_cmd_opcode_i (req_cmd_opcode_i),
    .req_cmd_addr_i   (req_cmd_addr_i),
    .req_cmd_data_i   (req_cmd_data_i),
    .req_cmd_yumi_o   (req_cmd_yumi_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .io_cmd_ready_i   (io_cmd_ready_i),
    .clint_cmd_ready_i(clint_cmd_ready),
    .loop_cmd_ready_i (loop_cmd_ready),
    .cmd_opcode_o     (cmd_opcode),
    .cmd_addr_o       (cmd_addr),
    .cmd_lce_id_o     (cmd_lce_id),
    .cmd_data_o       (cmd_data),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .io_cmd_v_o       (io_cmd_v_o),
    .clint_cmd_v_o    (clint_cmd_v),
    .loop_cmd_v_o     (loop_cmd_v)
  );

  // One shared command bus feeds every target
  assign mem_cmd_opcode_o = cmd_opcode;
  assign mem_cmd_addr_o   = cmd_addr;
  assign mem_cmd_lce_id_o = cmd_lce_id;
  assign mem_cmd_data_o   = cmd_data;
  assign io_cmd_opcode_o  = cmd_opcode;
  assign io_cmd_addr_o    = cmd_addr;
  assign io_cmd_lce_id_o  = cmd_lce_id;
  assign io_cmd_data_o    = cmd_data;

  clint_slice u_clint (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_v_i       (clint_cmd_v),
    .cmd_opcode_i  (cmd_opcode),
    .cmd_addr_i    (cmd_addr),
    .cmd_lce_id_i  (cmd_lce_id),
    .cmd_data_i    (cmd_data),
    .cmd_ready_o   (clint_cmd_ready),
    .resp_v_o      (clint_resp_v),
    .resp_opcode_o (clint_resp_opcode),
    .resp_addr_o   (clint_resp_addr),
    .resp_lce_id_o (clint_resp_lce_id),
    .resp_data_o   (clint_resp_data),
    .resp_yumi_i   (src_yumi[SRC_CLINT]),
    .timer_irq_o   (timer_irq_o),
    .software_irq_o(software_irq_o)
  );

  loopback_slice u_loopback (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmd_v_i      (loop_cmd_v),
    .cmd_opcode_i (cmd_opcode),
    .cmd_addr_i   (cmd_addr),
    .cmd_lce_id_i (cmd_lce_id),
    .cmd_ready_o  (loop_cmd_ready),
    .resp_v_o     (loop_resp_v),
    .resp_opcode_o(loop_resp_opcode),
    .resp_addr_o  (loop_resp_addr),
    .resp_lce_id_o(loop_resp_lce_id),
    .resp_data_o  (loop_resp_data),
    .resp_yumi_i  (src_yumi[SRC_LOOP])
  );

  // Slots run from index 0 upward as CLINT, I/O, memory, loopback
  assign src_v      = '{clint_resp_v, io_resp_v_i, mem_resp_v_i, loop_resp_v};
  assign src_opcode = '{clint_resp_opcode, io_resp_opcode_i, mem_resp_opcode_i, loop_resp_opcode};
  assign src_addr   = '{clint_resp_addr, io_resp_addr_i, mem_resp_addr_i, loop_resp_addr};
  assign src_lce_id = '{clint_resp_lce_id, io_resp_lce_id_i, mem_resp_lce_id_i, loop_resp_lce_id};
  assign src_data   = '{clint_resp_data, io_resp_data_i, mem_resp_data_i, loop_resp_data};

  resp_router u_resp_router (
    .src_resp_v_i     (src_v),
    .src_resp_opcode_i(src_opcode),
    .src_resp_addr_i  (src_addr),
    .src_resp_lce_id_i(src_lce_id),
    .src_resp_data_i  (src_data),
    .src_resp_yumi_o  (src_yumi),
    .req_resp_ready_i (req_resp_ready_i),
    .req_resp_v_o     (req_resp_v_o),
    .resp_opcode_o    (req_resp_opcode_o),
    .resp_addr_o      (req_resp_addr_o),
    .resp_data_o      (req_resp_data_o)
  );

  assign mem_resp_ready_o = src_yumi[SRC_MEM];
  assign io_resp_yumi_o   = src_yumi[SRC_IO];

endmodule

//--- src/loopback_slice.sv
`timescale 1ns/1ps

module loopback_slice
  import uc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              cmd_v_i,
  input  mem_op_e           cmd_opcode_i,
  input  addr_u             cmd_addr_i,
  input  lce_id_t           cmd_lce_id_i,
  output logic              cmd_ready_o,

  output logic              resp_v_o,
  output mem_op_e           resp_opcode_o,
  output addr_u             resp_addr_o,
  output lce_id_t           resp_lce_id_o,
  output logic [DATA_W-1:0] resp_data_o,
  input  logic              resp_yumi_i
);

  logic accept;

  assign cmd_ready_o = ~resp_v_o;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_o <= 1'b0;
    else if (accept)
      resp_v_o <= 1'b1;
    else if (resp_yumi_i)
      resp_v_o <= 1'b0;
  end

  // Header is echoed back as is
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_opcode_o <= cmd_opcode_i;
      resp_addr_o   <= cmd_addr_i;
      resp_lce_id_o <= cmd_lce_id_i;
    end
  end

  assign resp_data_o = '0;

endmodule

//--- src/clint_slice.sv
`timescale 1ns/1ps

module clint_slice
  import uc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              cmd_v_i,
  input  mem_op_e           cmd_opcode_i,
  input  addr_u             cmd_addr_i,
  input  lce_id_t           cmd_lce_id_i,
  input  logic [DATA_W-1:0] cmd_data_i,
  output logic              cmd_ready_o,

  output logic              resp_v_o,
  output mem_op_e           resp_opcode_o,
  output addr_u             resp_addr_o,
  output lce_id_t           resp_lce_id_o,
  output logic [DATA_W-1:0] resp_data_o,
  input  logic              resp_yumi_i,

  output logic              timer_irq_o,
  output logic              software_irq_o
);

  logic              resp_v_r;
  logic [DATA_W-1:0] mtime_r;
  logic [DATA_W-1:0] mtimecmp_r;
  logic              msip_r;
  logic              accept;
  logic              is_write;
  logic [DATA_W-1:0] rd_data;

  // One response in flight at a time
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_opcode_i == op_write);

  always_comb
  begin
    case (cmd_addr_i.loc.offset)
      MSIP_OFF:     rd_data = {{(DATA_W-1){1'b0}}, msip_r};
      MTIMECMP_OFF: rd_data = mtimecmp_r;
      MTIME_OFF:    rd_data = mtime_r;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_r   <= 1'b0;
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
    end
    else
    begin
      mtime_r <= mtime_r + 1'b1;
      if (accept)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
      if (accept & is_write & (cmd_addr_i.loc.offset == MTIMECMP_OFF))
        mtimecmp_r <= cmd_data_i;
      if (accept & is_write & (cmd_addr_i.loc.offset == MSIP_OFF))
        msip_r <= cmd_data_i[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_opcode_o <= cmd_opcode_i;
      resp_addr_o   <= cmd_addr_i;
      resp_lce_id_o <= cmd_lce_id_i;
      resp_data_o   <= is_write ? '0 : rd_data;
    end
  end

  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

//--- src/resp_router.sv
`timescale 1ns/1ps

module resp_router
  import uc_pkg::*;
(
  input  logic              src_resp_v_i      [NUM_SRC],
  input  mem_op_e           src_resp_opcode_i [NUM_SRC],
  input  addr_u             src_resp_addr_i   [NUM_SRC],
  input  lce_id_t           src_resp_lce_id_i [NUM_SRC],
  input  logic [DATA_W-1:0] src_resp_data_i   [NUM_SRC],
  output logic              src_resp_yumi_o   [NUM_SRC],

  input  logic              req_resp_ready_i  [NUM_REQ],
  output logic              req_resp_v_o      [NUM_REQ],

  output mem_op_e           resp_opcode_o,
  output addr_u             resp_addr_o,
  output logic [DATA_W-1:0] resp_data_o
);

  logic                       any_v;
  logic [$clog2(NUM_SRC)-1:0] grant_src;
  lce_id_t                    dest_id;
  logic                       delivered;

  // Loopback sits in the top slot and goes first
  always_comb
  begin
    any_v     = 1'b0;
    grant_src = '0;
    for (int i = 0; i < NUM_SRC; i++)
    begin
      if (src_resp_v_i[i])
      begin
        any_v     = 1'b1;
        grant_src = ($clog2(NUM_SRC))'(i);
      end
    end
  end

  assign resp_opcode_o = src_resp_opcode_i[grant_src];
  assign resp_addr_o   = src_resp_addr_i[grant_src];
  assign resp_data_o   = src_resp_data_i[grant_src];
  assign dest_id       = src_resp_lce_id_i[grant_src];

  // Steer to the requester tagged in the response
  always_comb
  begin
    delivered = 1'b0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      req_resp_v_o[i] = any_v & (dest_id == lce_id_t'(i));
      delivered       = delivered | (req_resp_v_o[i] & req_resp_ready_i[i]);
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_SRC; i++)
    begin
      src_resp_yumi_o[i] = delivered & (grant_src == ($clog2(NUM_SRC))'(i));
    end
  end

endmodule

//--- src/cmd_router.sv
`timescale 1ns/1ps

module cmd_router
  import uc_pkg::*;
(
  input  logic              req_cmd_v_i      [NUM_REQ],
  input  mem_op_e           req_cmd_opcode_i [NUM_REQ],
  input  addr_u             req_cmd_addr_i   [NUM_REQ],
  input  logic [DATA_W-1:0] req_cmd_data_i   [NUM_REQ],
  output logic              req_cmd_yumi_o   [NUM_REQ],

  input  logic              mem_cmd_ready_i,
  input  logic              io_cmd_ready_i,
  input  logic              clint_cmd_ready_i,
  input  logic              loop_cmd_ready_i,

  output mem_op_e           cmd_opcode_o,
  output addr_u             cmd_addr_o,
  output lce_id_t           cmd_lce_id_o,
  output logic [DATA_W-1:0] cmd_data_o,

  output logic              mem_cmd_v_o,
  output logic              io_cmd_v_o,
  output logic              clint_cmd_v_o,
  output logic              loop_cmd_v_o
);

  logic    any_v;
  lce_id_t grant_id;
  logic    is_local;
  logic    is_mem;
  logic    is_io;
  logic    is_clint;
  logic    is_loop;
  logic    accept;

  // Highest valid index wins
  always_comb
  begin
    any_v    = 1'b0;
    grant_id = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (req_cmd_v_i[i])
      begin
        any_v    = 1'b1;
        grant_id = lce_id_t'(i);
      end
    end
  end

  assign cmd_opcode_o = req_cmd_opcode_i[grant_id];
  assign cmd_addr_o   = req_cmd_addr_i[grant_id];
  assign cmd_data_o   = req_cmd_data_i[grant_id];
  assign cmd_lce_id_o = grant_id;

  assign is_local = (cmd_addr_o.paddr < DRAM_BASE);
  assign is_mem   = ~is_local | (cmd_addr_o.loc.dev == CACHE_DEV);
  assign is_io    = is_local & (cmd_addr_o.loc.dev == HOST_DEV);
  assign is_clint = is_local & (cmd_addr_o.loc.dev == CLINT_DEV);
  // Unmapped local space falls through to loopback
  assign is_loop  = ~is_mem & ~is_io & ~is_clint;

  assign mem_cmd_v_o   = any_v & is_mem & mem_cmd_ready_i;
  assign io_cmd_v_o    = any_v & is_io & io_cmd_ready_i;
  assign clint_cmd_v_o = any_v & is_clint & clint_cmd_ready_i;
  assign loop_cmd_v_o  = any_v & is_loop & loop_cmd_ready_i;

  assign accept = mem_cmd_v_o | io_cmd_v_o | clint_cmd_v_o | loop_cmd_v_o;

  always_comb
  begin
    for (int i = 0; i < NUM_REQ; i++)
    begin
      req_cmd_yumi_o[i] = accept & (grant_id == lce_id_t'(i));
    end
  end

endmodule

//--- src/uc_pkg.sv
package uc_pkg;

  localparam int PADDR_W  = 32;
  localparam int DATA_W   = 64;
  localparam int LCE_ID_W = 2;
  localparam int NUM_REQ  = 3;
  localparam int NUM_SRC  = 4;

  // Everything below this address is local device space
  localparam logic [PADDR_W-1:0] DRAM_BASE = 32'h8000_0000;

  localparam int DEV_W    = 4;
  localparam int OFFSET_W = 20;

  localparam logic [DEV_W-1:0] HOST_DEV  = 4'd0;
  localparam logic [DEV_W-1:0] CLINT_DEV = 4'd1;
  localparam logic [DEV_W-1:0] CACHE_DEV = 4'd3;

  // CLINT register offsets
  localparam logic [OFFSET_W-1:0] MSIP_OFF     = 20'h0_0000;
  localparam logic [OFFSET_W-1:0] MTIMECMP_OFF = 20'h0_4000;
  localparam logic [OFFSET_W-1:0] MTIME_OFF    = 20'h0_BFF8;

  // Response source slots, the highest slot wins arbitration
  localparam int SRC_CLINT = 0;
  localparam int SRC_IO    = 1;
  localparam int SRC_MEM   = 2;
  localparam int SRC_LOOP  = 3;

  typedef enum logic [1:0] {
    op_read  = 2'b00,
    op_write = 2'b01
  } mem_op_e;

  typedef logic [LCE_ID_W-1:0] lce_id_t;

  typedef struct packed {
    logic [PADDR_W-DEV_W-OFFSET_W-1:0] rsvd;
    logic [DEV_W-1:0]                  dev;
    logic [OFFSET_W-1:0]               offset;
  } local_addr_s;

  // Flat view for the DRAM compare, local view for device decode
  typedef union packed {
    logic [PADDR_W-1:0] paddr;
    local_addr_s        loc;
  } addr_u;

endpackage
